// File: hdl/p2p_pkg.sv
package p2p_pkg;

    // ==================================================================
    // sizes
    // ==================================================================

    localparam int num_ports = 4;
    localparam int data_w    = 64;
    localparam int cnt_w     = 64;
    localparam int reg_w     = 32;

    // register block codes, address bits 15:12
    localparam logic [3:0] blk_config  = 4'h0;
    localparam logic [3:0] blk_ingress = 4'h8;
    localparam logic [3:0] blk_egress  = 4'hb;

    // pad, spare and zero fields must all read as zero
    localparam logic [31:0] addr_mbz_mask = 32'hffff_01f3;

    // returned for any address outside the map
    localparam logic [31:0] unmapped_rdata = 32'hdeadbeef;

    // slot of each count inside one stage's bundle, {kind, bytes}
    localparam int idx_kept_pkts  = 0;
    localparam int idx_kept_bytes = 1;
    localparam int idx_drop_pkts  = 2;
    localparam int idx_drop_bytes = 3;

    // ==================================================================
    // types
    // ==================================================================

    typedef enum logic [1:0] {
        cmac_port0 = 2'd0,
        cmac_port1 = 2'd1,
        host_port0 = 2'd2,
        host_port1 = 2'd3
    } port_t;

    // one stream beat, nbytes is 1..8 and only short on the last beat
    typedef struct packed {
        logic              valid;
        logic              last;
        logic [3:0]        nbytes;
        logic [data_w-1:0] data;
    } beat_t;

    typedef struct packed {
        port_t out_port;
        logic  enable;
    } in_cfg_t;

    // 32-bit half of a 64-bit counter
    typedef enum logic [1:0] {
        pkt_hi  = 2'd0,
        pkt_lo  = 2'd1,
        byte_hi = 2'd2,
        byte_lo = 2'd3
    } cntr_word_t;

    typedef struct packed {
        logic [15:0] pad;
        logic [3:0]  block;
        port_t       port;
        // 0 probe, 1 drops
        logic        kind;
        logic [4:0]  spare;
        cntr_word_t  word;
        logic [1:0]  zero;
    } cntr_fields_t;

    // same address word seen raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        cntr_fields_t fields;
    } cntr_addr_t;

endpackage

// File: hdl/probe_counter.sv
module probe_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  p2p_pkg::beat_t            beat,
    input  logic                      hit,
    output logic [p2p_pkg::cnt_w-1:0] pkts,
    output logic [p2p_pkg::cnt_w-1:0] bytes
);

    import p2p_pkg::*;

    // bytes of the packet seen so far, not yet visible on bytes
    logic [cnt_w-1:0] acc;
    logic [cnt_w-1:0] beat_bytes;

    assign beat_bytes = cnt_w'(beat.nbytes);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc   <= '0;
            pkts  <= '0;
            bytes <= '0;
        end else if (beat.valid && hit) begin
            if (beat.last) begin
                // whole packet lands in one cycle
                pkts  <= pkts + cnt_w'(1);
                bytes <= bytes + acc + beat_bytes;
                acc   <= '0;
            end else begin
                acc <= acc + beat_bytes;
            end
        end
    end

endmodule

// File: hdl/ingress_filter.sv
module ingress_filter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  p2p_pkg::beat_t            in_beat,
    input  p2p_pkg::in_cfg_t          cfg,
    output p2p_pkg::beat_t            out_beat,
    output p2p_pkg::port_t            dest,
    output logic [p2p_pkg::cnt_w-1:0] kept_pkts,
    output logic [p2p_pkg::cnt_w-1:0] kept_bytes,
    output logic [p2p_pkg::cnt_w-1:0] drop_pkts,
    output logic [p2p_pkg::cnt_w-1:0] drop_bytes
);

    import p2p_pkg::*;

    logic  in_pkt;
    logic  first;
    logic  keep_lat;
    logic  keep_now;
    port_t dest_lat;
    port_t dest_now;
    logic  vld_q;
    logic  keep_q;
    beat_t beat_q;
    beat_t stg_beat;

    // first valid beat after reset or after a last
    assign first = in_beat.valid && !in_pkt;

    // decision taken from cfg on the first beat, held to the last
    assign keep_now = first ? cfg.enable : keep_lat;
    assign dest_now = first ? cfg.out_port : dest_lat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            keep_lat <= 1'b0;
            dest_lat <= cmac_port0;
            vld_q    <= 1'b0;
            keep_q   <= 1'b0;
        end else begin
            if (in_beat.valid) begin
                in_pkt <= !in_beat.last;
            end
            if (first) begin
                keep_lat <= cfg.enable;
                dest_lat <= cfg.out_port;
            end
            vld_q  <= in_beat.valid;
            keep_q <= keep_now;
        end
    end

    // stage register, payload and steering
    always_ff @(posedge clk) begin
        beat_q <= in_beat;
        dest   <= dest_now;
    end

    always_comb begin
        stg_beat       = beat_q;
        stg_beat.valid = vld_q;
        // dropped packets simply never show valid downstream
        out_beat       = stg_beat;
        out_beat.valid = vld_q && keep_q;
    end

    // counters look at the registered beat so they trail it by a cycle
    probe_counter u_kept (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (stg_beat),
        .hit   (keep_q),
        .pkts  (kept_pkts),
        .bytes (kept_bytes)
    );

    probe_counter u_drop (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (stg_beat),
        .hit   (!keep_q),
        .pkts  (drop_pkts),
        .bytes (drop_bytes)
    );

endmodule

// File: hdl/port_switch.sv
module port_switch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  p2p_pkg::beat_t [p2p_pkg::num_ports-1:0]       in_beat,
    input  p2p_pkg::port_t [p2p_pkg::num_ports-1:0]       dest,
    output p2p_pkg::beat_t [p2p_pkg::num_ports-1:0]       out_beat
);

    import p2p_pkg::*;

    beat_t [num_ports-1:0] sel_beat;
    beat_t [num_ports-1:0] sw_q;
    logic  [num_ports-1:0] vld_q;

    // ==================================================================
    // crossbar select
    // ==================================================================

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            sel_beat[o] = '0;
            // scan high to low so the lowest index ends up winning
            for (int i = num_ports - 1; i >= 0; i--) begin
                if (in_beat[i].valid && dest[i] == port_t'(o)) begin
                    sel_beat[o] = in_beat[i];
                end
            end
        end
    end

    // ==================================================================
    // output register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                vld_q[o] <= sel_beat[o].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        sw_q <= sel_beat;
    end

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            out_beat[o]       = sw_q[o];
            out_beat[o].valid = vld_q[o];
        end
    end

endmodule

// File: hdl/egress_filter.sv
module egress_filter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  p2p_pkg::beat_t            in_beat,
    input  logic                      enable,
    output p2p_pkg::beat_t            out_beat,
    output logic [p2p_pkg::cnt_w-1:0] kept_pkts,
    output logic [p2p_pkg::cnt_w-1:0] kept_bytes,
    output logic [p2p_pkg::cnt_w-1:0] drop_pkts,
    output logic [p2p_pkg::cnt_w-1:0] drop_bytes
);

    import p2p_pkg::*;

    logic  in_pkt;
    logic  first;
    logic  keep_lat;
    logic  keep_now;
    logic  vld_q;
    logic  keep_q;
    beat_t beat_q;
    beat_t stg_beat;

    // packet position on the switch output
    assign first    = in_beat.valid && !in_pkt;
    assign keep_now = first ? enable : keep_lat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            keep_lat <= 1'b0;
            vld_q    <= 1'b0;
            keep_q   <= 1'b0;
        end else begin
            if (in_beat.valid) begin
                in_pkt <= !in_beat.last;
            end
            // a port disabled mid-packet still lets this packet through
            if (first) begin
                keep_lat <= enable;
            end
            vld_q  <= in_beat.valid;
            keep_q <= keep_now;
        end
    end

    always_ff @(posedge clk) begin
        beat_q <= in_beat;
    end

    always_comb begin
        stg_beat       = beat_q;
        stg_beat.valid = vld_q;
        out_beat       = stg_beat;
        out_beat.valid = vld_q && keep_q;
    end

    probe_counter u_kept (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (stg_beat),
        .hit   (keep_q),
        .pkts  (kept_pkts),
        .bytes (kept_bytes)
    );

    probe_counter u_drop (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (stg_beat),
        .hit   (!keep_q),
        .pkts  (drop_pkts),
        .bytes (drop_bytes)
    );

endmodule

// File: hdl/cntr_regs.sv
module cntr_regs (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               reg_wr,
    input  logic                                               reg_rd,
    input  p2p_pkg::cntr_addr_t                                reg_addr,
    input  logic [p2p_pkg::reg_w-1:0]                          reg_wdata,
    output logic [p2p_pkg::reg_w-1:0]                          reg_rdata,
    output logic                                               reg_rvalid,
    output p2p_pkg::in_cfg_t [p2p_pkg::num_ports-1:0]          in_cfg,
    output logic [p2p_pkg::num_ports-1:0]                      eg_enable,
    input  logic [p2p_pkg::num_ports-1:0][3:0][p2p_pkg::cnt_w-1:0] ing_cnt,
    input  logic [p2p_pkg::num_ports-1:0][3:0][p2p_pkg::cnt_w-1:0] eg_cnt
);

    import p2p_pkg::*;

    logic             addr_ok;
    logic             is_cfg;
    logic             is_ing;
    logic             is_eg;
    logic             sel_bytes;
    logic             sel_lo;
    logic [1:0]       cnt_idx;
    logic [cnt_w-1:0] cnt_val;
    logic [reg_w-1:0] rd_mux;
    port_t            port;

    // ==================================================================
    // address decode
    // ==================================================================

    // reserved bits checked on the raw word, the rest through fields
    assign addr_ok = (reg_addr.raw & addr_mbz_mask) == '0;
    assign port    = reg_addr.fields.port;

    // config words only live at word offset 0
    assign is_cfg = addr_ok && reg_addr.fields.block == blk_config
                    && reg_addr.fields.word == pkt_hi;
    assign is_ing = addr_ok && reg_addr.fields.block == blk_ingress;
    assign is_eg  = addr_ok && reg_addr.fields.block == blk_egress;

    assign sel_bytes = reg_addr.fields.word inside {byte_hi, byte_lo};
    assign sel_lo    = reg_addr.fields.word inside {pkt_lo, byte_lo};

    // slot within a bundle is {kind, bytes}
    assign cnt_idx = {reg_addr.fields.kind, sel_bytes};
    assign cnt_val = is_ing ? ing_cnt[port][cnt_idx] : eg_cnt[port][cnt_idx];

    // ==================================================================
    // configuration registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // identity map, every port open
            for (int p = 0; p < num_ports; p++) begin
                in_cfg[p].out_port <= port_t'(p);
                in_cfg[p].enable   <= 1'b1;
            end
            eg_enable <= '1;
        end else if (reg_wr && is_cfg) begin
            if (!reg_addr.fields.kind) begin
                // bits 1:0 out_port, bit 2 enable
                in_cfg[port].out_port <= port_t'(reg_wdata[1:0]);
                in_cfg[port].enable   <= reg_wdata[2];
            end else begin
                eg_enable[port] <= reg_wdata[0];
            end
        end
    end

    // ==================================================================
    // read path, one cycle from reg_rd to reg_rvalid
    // ==================================================================

    always_comb begin
        rd_mux = unmapped_rdata;
        if (is_ing || is_eg) begin
            rd_mux = sel_lo ? cnt_val[reg_w-1:0] : cnt_val[cnt_w-1:reg_w];
        end else if (is_cfg && !reg_addr.fields.kind) begin
            rd_mux = {29'h0, in_cfg[port].enable, in_cfg[port].out_port};
        end else if (is_cfg) begin
            rd_mux = {31'h0, eg_enable[port]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

// File: hdl/p2p_datapath.sv
module p2p_datapath (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  p2p_pkg::beat_t [p2p_pkg::num_ports-1:0] rx_beat,
    output p2p_pkg::beat_t [p2p_pkg::num_ports-1:0] tx_beat,
    input  logic                                    reg_wr,
    input  logic                                    reg_rd,
    input  p2p_pkg::cntr_addr_t                     reg_addr,
    input  logic [p2p_pkg::reg_w-1:0]               reg_wdata,
    output logic [p2p_pkg::reg_w-1:0]               reg_rdata,
    output logic                                    reg_rvalid
);

    import p2p_pkg::*;

    // stream between stages
    beat_t   [num_ports-1:0] ing_beat;
    port_t   [num_ports-1:0] ing_dest;
    beat_t   [num_ports-1:0] sw_beat;

    // configuration out of the register block
    in_cfg_t [num_ports-1:0] in_cfg;
    logic    [num_ports-1:0] eg_enable;

    // count bundles per port, indexed by idx_* slots
    logic [num_ports-1:0][3:0][cnt_w-1:0] ing_cnt;
    logic [num_ports-1:0][3:0][cnt_w-1:0] eg_cnt;

    // ==================================================================
    // ingress, one filter per input
    // ==================================================================

    for (genvar i = 0; i < num_ports; i++) begin : g_ing
        ingress_filter u_ing (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_beat    (rx_beat[i]),
            .cfg        (in_cfg[i]),
            .out_beat   (ing_beat[i]),
            .dest       (ing_dest[i]),
            .kept_pkts  (ing_cnt[i][idx_kept_pkts]),
            .kept_bytes (ing_cnt[i][idx_kept_bytes]),
            .drop_pkts  (ing_cnt[i][idx_drop_pkts]),
            .drop_bytes (ing_cnt[i][idx_drop_bytes])
        );
    end

    // ==================================================================
    // switch
    // ==================================================================

    port_switch u_switch (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (ing_beat),
        .dest     (ing_dest),
        .out_beat (sw_beat)
    );

    // ==================================================================
    // egress, one filter per output
    // ==================================================================

    for (genvar i = 0; i < num_ports; i++) begin : g_eg
        egress_filter u_eg (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_beat    (sw_beat[i]),
            .enable     (eg_enable[i]),
            .out_beat   (tx_beat[i]),
            .kept_pkts  (eg_cnt[i][idx_kept_pkts]),
            .kept_bytes (eg_cnt[i][idx_kept_bytes]),
            .drop_pkts  (eg_cnt[i][idx_drop_pkts]),
            .drop_bytes (eg_cnt[i][idx_drop_bytes])
        );
    end

    // register port, config and counter readback
    cntr_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .in_cfg     (in_cfg),
        .eg_enable  (eg_enable),
        .ing_cnt    (ing_cnt),
        .eg_cnt     (eg_cnt)
    );

endmodule

// File: verif/p2p_datapath_tb.sv
module p2p_datapath_tb;

    import p2p_pkg::*;

    localparam int n_tests = 6;
    // config writes, config reads, one unmapped read, 64 counter halves
    localparam int accesses_per_test = 2 * num_ports + 2 * num_ports + 1 + 64;
    localparam int drain_limit = 20;
    localparam logic [31:0] lfsr_mask = 32'hd000_0001;

    // per input {enable, out_port}, input 3 on the left
    localparam logic [11:0] map_ident = {3'b111, 3'b110, 3'b101, 3'b100};
    // beats per packet and final nbytes, one nibble per port, port 3 on the left
    localparam logic [15:0] beats_mix = 16'h2513;
    localparam logic [15:0] tail_mix  = 16'h1538;

    // one row of the test table, expected packet counts one nibble per port
    typedef struct packed {
        logic            do_cfg;
        logic [3:0][2:0] in_map;
        logic [3:0]      eg_en;
        logic [1:0]      n_pkts;
        logic [3:0][3:0] n_beats;
        logic [3:0][3:0] tail;
        logic            mid_off;
        logic [15:0]     ing_kept;
        logic [15:0]     ing_drop;
        logic [15:0]     eg_kept;
        logic [15:0]     eg_drop;
    } test_t;

    logic                  clk;
    logic                  rst_n;
    beat_t [num_ports-1:0] rx_beat;
    beat_t [num_ports-1:0] tx_beat;
    logic                  reg_wr;
    logic                  reg_rd;
    cntr_addr_t            reg_addr;
    logic [reg_w-1:0]      reg_wdata;
    logic [reg_w-1:0]      reg_rdata;
    logic                  reg_rvalid;

    test_t tests [n_tests];
    string names [n_tests];

    // scoreboard, expected beats per output with their input cycle
    beat_t            exp_beat [num_ports][$];
    int               exp_cyc [num_ports][$];
    // expected bytes by {ing kept, ing drop, eg kept, eg drop} and port
    logic [cnt_w-1:0] exp_bytes [4][num_ports];
    logic [3:0][2:0]  cur_map;
    logic [3:0]       cur_eg;

    // reg_rd as sampled at the last rising edge
    logic rd_q;

    logic [31:0] lfsr;
    int          cyc;
    int          limit;
    int          err_count;
    int          check_count;

    p2p_datapath u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_beat    (rx_beat),
        .tx_beat    (tx_beat),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================================
    // cycle count and watchdog
    // ==================================================================

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==================================================================
    // helpers
    // ==================================================================

    // galois lfsr, one step per data bit
    function automatic logic [63:0] rand_word();
        logic [63:0] w;
        logic        b;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? lfsr_mask : 32'h0);
            w    = {w[62:0], b};
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            $display("FAIL %s: got %h expected %h", name, got, want);
            err_count++;
        end
    endtask

    function automatic logic [31:0] make_addr(input logic [3:0] blk, input int port,
                                              input logic kind, input cntr_word_t word);
        cntr_addr_t a;
        a.raw          = '0;
        a.fields.block = blk;
        a.fields.port  = port_t'(port);
        a.fields.kind  = kind;
        a.fields.word  = word;
        return a.raw;
    endfunction

    // every drive happens 2 units after a rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        reg_wr       = 1'b1;
        reg_addr.raw = addr;
        reg_wdata    = data;
        step();
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
        reg_rd       = 1'b1;
        reg_addr.raw = addr;
        step();
        reg_rd = 1'b0;
        // rdata arrives with the rvalid pulse one cycle after rd
        data = reg_rdata;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) step();
        rst_n = 1'b1;
    endtask

    // ==================================================================
    // configuration
    // ==================================================================

    task automatic write_config(input test_t t);
        for (int p = 0; p < num_ports; p++) begin
            reg_write(make_addr(blk_config, p, 1'b0, pkt_hi), {29'h0, t.in_map[p]});
            reg_write(make_addr(blk_config, p, 1'b1, pkt_hi), {31'h0, t.eg_en[p]});
        end
    endtask

    task automatic check_config(input test_t t);
        logic [31:0] rd;
        for (int p = 0; p < num_ports; p++) begin
            reg_read(make_addr(blk_config, p, 1'b0, pkt_hi), rd);
            check($sformatf("in_cfg[%0d]", p), rd, {29'h0, t.in_map[p]});
            reg_read(make_addr(blk_config, p, 1'b1, pkt_hi), rd);
            check($sformatf("eg_enable[%0d]", p), rd, {31'h0, t.eg_en[p]});
        end
        // block 5 is outside the map
        reg_read(32'h0000_5000, rd);
        check("unmapped rdata", rd, 32'hdeadbeef);
    endtask

    // ==================================================================
    // traffic and scoreboard
    // ==================================================================

    // decide a packet's fate from the config seen at its first beat
    function automatic int route_packet(input int p, input int tot);
        int o;
        if (!cur_map[p][2]) begin
            exp_bytes[1][p] += tot;
            return -1;
        end
        exp_bytes[0][p] += tot;
        o = int'(cur_map[p][1:0]);
        if (!cur_eg[o]) begin
            exp_bytes[3][o] += tot;
            return -1;
        end
        exp_bytes[2][o] += tot;
        return o;
    endfunction

    task automatic send_traffic(input test_t t);
        int    max_b;
        int    nb;
        int    dest [num_ports];
        beat_t b;
        max_b = 0;
        for (int p = 0; p < num_ports; p++) begin
            if (int'(t.n_beats[p]) > max_b) max_b = int'(t.n_beats[p]);
        end
        // all ports start their packets together
        for (int k = 0; k < int'(t.n_pkts); k++) begin
            for (int i = 0; i < max_b; i++) begin
                for (int p = 0; p < num_ports; p++) begin
                    nb = int'(t.n_beats[p]);
                    b  = '0;
                    if (i < nb) begin
                        b.valid  = 1'b1;
                        b.last   = (i == nb - 1);
                        b.nbytes = b.last ? t.tail[p] : 4'd8;
                        b.data   = rand_word();
                        if (i == 0) dest[p] = route_packet(p, (nb - 1) * 8 + int'(t.tail[p]));
                        if (dest[p] >= 0) begin
                            exp_beat[dest[p]].push_back(b);
                            exp_cyc[dest[p]].push_back(cyc);
                        end
                    end
                    rx_beat[p] = b;
                end
                // turn input 0 off while its first packet is in flight
                if (t.mid_off && k == 0 && i == 1) begin
                    reg_wr       = 1'b1;
                    reg_addr.raw = make_addr(blk_config, 0, 1'b0, pkt_hi);
                    reg_wdata    = {29'h0, 1'b0, cur_map[0][1:0]};
                    cur_map[0][2] = 1'b0;
                end else begin
                    reg_wr = 1'b0;
                end
                step();
            end
        end
        rx_beat = '0;
        reg_wr  = 1'b0;
    endtask

    function automatic logic pending();
        for (int o = 0; o < num_ports; o++) begin
            if (exp_beat[o].size() != 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() && n < drain_limit) begin
            step();
            n++;
        end
        for (int o = 0; o < num_ports; o++) begin
            if (exp_beat[o].size() != 0) begin
                $display("output %0d never sent %0d expected beats", o, exp_beat[o].size());
                err_count++;
                exp_beat[o].delete();
                exp_cyc[o].delete();
            end
        end
        // counters trail the last beat by one cycle after each stage
        repeat (6) step();
    endtask

    always @(posedge clk) begin
        rd_q <= reg_rd;
    end

    // tx beats and rvalid are stable at the falling edge
    always @(negedge clk) begin
        beat_t want;
        int    t0;
        for (int o = 0; o < num_ports; o++) begin
            if (tx_beat[o].valid === 1'b1) begin
                if (exp_beat[o].size() == 0) begin
                    $display("unexpected beat on tx_beat[%0d] at cycle %0d", o, cyc);
                    err_count++;
                end else begin
                    want = exp_beat[o].pop_front();
                    t0   = exp_cyc[o].pop_front();
                    check($sformatf("tx_beat[%0d].data", o), tx_beat[o].data, want.data);
                    check($sformatf("tx_beat[%0d].last_nbytes", o),
                          {tx_beat[o].last, tx_beat[o].nbytes}, {want.last, want.nbytes});
                    check($sformatf("tx_beat[%0d].latency", o), 64'(cyc - t0), 64'd3);
                end
            end
        end
        // rvalid pulses exactly one cycle after each rd
        if (rst_n === 1'b1) begin
            check("reg_rvalid", reg_rvalid, rd_q);
        end
    end

    // ==================================================================
    // counter readback
    // ==================================================================

    function automatic logic [3:0] exp_pkts(input test_t t, input int sel, input int p);
        logic [15:0] row;
        case (sel)
            0: row = t.ing_kept;
            1: row = t.ing_drop;
            2: row = t.eg_kept;
            default: row = t.eg_drop;
        endcase
        return row[4*p +: 4];
    endfunction

    task automatic check_counters(input test_t t);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] pkts;
        logic [63:0] bytes;
        logic [3:0]  blk;
        int          sel;
        string       tag;
        for (int s = 0; s < 2; s++) begin
            blk = s ? blk_egress : blk_ingress;
            for (int p = 0; p < num_ports; p++) begin
                for (int k = 0; k < 2; k++) begin
                    sel = 2 * s + k;
                    tag = s ? "eg" : "ing";
                    tag = $sformatf("%s_%s", tag, k ? "drop" : "kept");
                    reg_read(make_addr(blk, p, k == 1, pkt_hi), hi);
                    reg_read(make_addr(blk, p, k == 1, pkt_lo), lo);
                    pkts = {hi, lo};
                    reg_read(make_addr(blk, p, k == 1, byte_hi), hi);
                    reg_read(make_addr(blk, p, k == 1, byte_lo), lo);
                    bytes = {hi, lo};
                    check($sformatf("%s_pkts[%0d]", tag, p), pkts, 64'(exp_pkts(t, sel, p)));
                    check($sformatf("%s_bytes[%0d]", tag, p), bytes, exp_bytes[sel][p]);
                end
            end
        end
    endtask

    // ==================================================================
    // test table
    // ==================================================================

    task automatic fill_table();
        names[0] = "reset_defaults";
        tests[0] = '{do_cfg: 1'b0, in_map: map_ident, eg_en: 4'hf, n_pkts: 2'd0,
                     n_beats: 16'h0, tail: 16'h0, mid_off: 1'b0,
                     ing_kept: 16'h0, ing_drop: 16'h0, eg_kept: 16'h0, eg_drop: 16'h0};
        names[1] = "reg_readback";
        tests[1] = '{do_cfg: 1'b1, in_map: {3'b101, 3'b100, 3'b111, 3'b110}, eg_en: 4'hf,
                     n_pkts: 2'd0, n_beats: 16'h0, tail: 16'h0, mid_off: 1'b0,
                     ing_kept: 16'h0, ing_drop: 16'h0, eg_kept: 16'h0, eg_drop: 16'h0};
        names[2] = "permute_fwd";
        tests[2] = '{do_cfg: 1'b1, in_map: {3'b100, 3'b101, 3'b110, 3'b111}, eg_en: 4'hf,
                     n_pkts: 2'd2, n_beats: beats_mix, tail: tail_mix, mid_off: 1'b0,
                     ing_kept: 16'h2222, ing_drop: 16'h0, eg_kept: 16'h2222, eg_drop: 16'h0};
        // input 1 off
        names[3] = "ingress_disable";
        tests[3] = '{do_cfg: 1'b1, in_map: {3'b111, 3'b110, 3'b001, 3'b100}, eg_en: 4'hf,
                     n_pkts: 2'd2, n_beats: beats_mix, tail: tail_mix, mid_off: 1'b0,
                     ing_kept: 16'h2202, ing_drop: 16'h0020, eg_kept: 16'h2202,
                     eg_drop: 16'h0};
        // output 1 off, input 0 lands on it
        names[4] = "egress_disable";
        tests[4] = '{do_cfg: 1'b1, in_map: {3'b110, 3'b111, 3'b100, 3'b101}, eg_en: 4'b1101,
                     n_pkts: 2'd2, n_beats: beats_mix, tail: tail_mix, mid_off: 1'b0,
                     ing_kept: 16'h2222, ing_drop: 16'h0, eg_kept: 16'h2202,
                     eg_drop: 16'h0020};
        names[5] = "mid_reconfig";
        tests[5] = '{do_cfg: 1'b1, in_map: map_ident, eg_en: 4'hf,
                     n_pkts: 2'd2, n_beats: beats_mix, tail: tail_mix, mid_off: 1'b1,
                     ing_kept: 16'h2221, ing_drop: 16'h0001, eg_kept: 16'h2221,
                     eg_drop: 16'h0};
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        test_t t;
        int    base;
        rst_n       = 1'b0;
        rx_beat     = '0;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        lfsr        = 32'hf5b;
        cyc         = 0;
        err_count   = 0;
        check_count = 0;
        fill_table();
        // every beat and register access, plus slack per test
        limit = 0;
        for (int n = 0; n < n_tests; n++) begin
            limit += 50 + accesses_per_test;
            for (int p = 0; p < num_ports; p++) begin
                limit += int'(tests[n].n_pkts) * int'(tests[n].n_beats[p]);
            end
        end
        for (int n = 0; n < n_tests; n++) begin
            t    = tests[n];
            base = err_count;
            apply_reset();
            if (t.do_cfg) write_config(t);
            cur_map = t.in_map;
            cur_eg  = t.eg_en;
            check_config(t);
            for (int s = 0; s < 4; s++) begin
                for (int p = 0; p < num_ports; p++) exp_bytes[s][p] = '0;
            end
            send_traffic(t);
            wait_drain();
            check_counters(t);
            $display("test %0d %s: %0d mismatches", n, names[n], err_count - base);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/p2p_pkg.sv
hdl/probe_counter.sv
hdl/ingress_filter.sv
hdl/port_switch.sv
hdl/egress_filter.sv
hdl/cntr_regs.sv
hdl/p2p_datapath.sv
verif/p2p_datapath_tb.sv

// File: Bender.yml
package:
  name: p2p_datapath

sources:
  - hdl/p2p_pkg.sv
  - hdl/probe_counter.sv
  - hdl/ingress_filter.sv
  - hdl/port_switch.sv
  - hdl/egress_filter.sv
  - hdl/cntr_regs.sv
  - hdl/p2p_datapath.sv
  - target: test
    files:
      - verif/p2p_datapath_tb.sv
